//--- rtl/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// entries in the buffer, power of two so pointers wrap on their own
`define ROB_DEPTH 8
`define ROB_WIDTH 3   // lanes for dispatch, completion and retire
`define ARCH_REGS 32  // architectural register file size
`define XLEN      32  // result word width

`endif

//--- rtl/rob_pkg.sv
`include "rob_cfg.svh"

package rob_pkg;

    // entry index that doubles as the rename tag for the map table
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t; // 0 = no destination

    typedef logic [`XLEN-1:0] data_t;

    // 0 .. ROB_WIDTH lanes
    typedef logic [$clog2(`ROB_WIDTH+1)-1:0] lane_cnt_t;

    // one buffer line of 41 bits
    typedef struct packed {
        logic      busy;        // allocated and not yet retired
        logic      done;        // result written back
        logic      mem_op;      // load or store
        arch_reg_t dest;        // architectural destination
        data_t     value;       // result from the cdb
        logic      take_branch; // resolved branch outcome
    } rob_entry_t;

endpackage

//--- rtl/rob_alloc_if.sv
`timescale 1ns/100ps
`include "rob_cfg.svh"

// allocation request from dispatch into the entry table
// the table takes whatever is presented each cycle
interface rob_alloc_if;

    // lanes accepted this cycle as a leading run
    rob_pkg::lane_cnt_t alloc_num;

    // first entry written with lane i landing at tail+i
    rob_pkg::rob_tag_t tail;

    // per lane destination zeroed when the instr has none
    rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] alloc_dest;

    logic [`ROB_WIDTH-1:0] alloc_mem; // per lane memory flag

    // dispatch side drives the request
    modport dispatch (
        output alloc_num,
        output tail,
        output alloc_dest,
        output alloc_mem
    );

    // table side only samples it
    modport tbl (
        input alloc_num,
        input tail,
        input alloc_dest,
        input alloc_mem
    );

endinterface

//--- rtl/rob_entry_table.sv
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_entry_table (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 squash,
    rob_alloc_if.tbl                             alloc,
    input  logic               [`ROB_WIDTH-1:0]  cdb_valid,
    input  rob_pkg::rob_tag_t  [`ROB_WIDTH-1:0]  cdb_tag,
    input  rob_pkg::data_t     [`ROB_WIDTH-1:0]  cdb_value,
    input  logic               [`ROB_WIDTH-1:0]  cdb_take_branch,
    input  rob_pkg::rob_tag_t                    head,
    input  rob_pkg::lane_cnt_t                   retire_num,
    output rob_pkg::rob_entry_t [`ROB_WIDTH-1:0] head_entries,
    output rob_pkg::lane_cnt_t                   free_slots
);

    rob_pkg::rob_entry_t [`ROB_DEPTH-1:0] entries;   // registered lines
    rob_pkg::rob_entry_t [`ROB_DEPTH-1:0] entries_n;
    rob_pkg::rob_tag_t   [`ROB_WIDTH-1:0] rt_idx;    // head, head+1, head+2
    rob_pkg::rob_tag_t   [`ROB_WIDTH-1:0] al_idx;    // tail, tail+1, tail+2
    logic [$clog2(`ROB_DEPTH):0]          free_cnt;  // needs room for DEPTH itself

    // lane addresses, wrap modulo depth
    always_comb begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            rt_idx[i] = head + rob_pkg::rob_tag_t'(i);
            al_idx[i] = alloc.tail + rob_pkg::rob_tag_t'(i);
        end
    end

    // next state: retire, then alloc, then completion
    always_comb begin
        entries_n = entries;

        // retired lines drop busy and done
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            if (retire_num > rob_pkg::lane_cnt_t'(i)) begin
                entries_n[rt_idx[i]].busy = 1'b0;
                entries_n[rt_idx[i]].done = 1'b0;
            end
        end

        for (int i = 0; i < `ROB_WIDTH; i++) begin
            if (alloc.alloc_num > rob_pkg::lane_cnt_t'(i)) begin
                entries_n[al_idx[i]].busy   = 1'b1;
                entries_n[al_idx[i]].done   = 1'b0;  // waits for its cdb result
                entries_n[al_idx[i]].mem_op = alloc.alloc_mem[i];
                entries_n[al_idx[i]].dest   = alloc.alloc_dest[i];
            end
        end

        // cdb lanes carry distinct tags, order among them is irrelevant
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            if (cdb_valid[i]) begin
                entries_n[cdb_tag[i]].done        = 1'b1;
                entries_n[cdb_tag[i]].value       = cdb_value[i];
                entries_n[cdb_tag[i]].take_branch = cdb_take_branch[i];
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            entries <= '0;
        end else if (squash) begin
            entries <= '0;  // flush everything in flight
        end else begin
            entries <= entries_n;
        end
    end

    // free line count from registered state
    always_comb begin
        free_cnt = '0;
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            if (!entries[k].busy) begin
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    // saturate at dispatch width
    assign free_slots = (free_cnt > `ROB_WIDTH) ? rob_pkg::lane_cnt_t'(`ROB_WIDTH)
                                                : rob_pkg::lane_cnt_t'(free_cnt);

    // three oldest lines for the retire logic
    always_comb begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            head_entries[i] = entries[rt_idx[i]];
        end
    end

endmodule

//--- rtl/rob_dispatch.sv
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_dispatch (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                squash,
    input  logic               [`ROB_WIDTH-1:0] dp_valid,
    input  logic               [`ROB_WIDTH-1:0] dp_dest_valid,
    input  rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] dp_dest,
    input  logic               [`ROB_WIDTH-1:0] dp_mem,
    rob_alloc_if.dispatch                       alloc,
    output rob_pkg::rob_tag_t  [`ROB_WIDTH-1:0] dp_tag,
    output logic               [`ROB_WIDTH-1:0] map_valid,
    output rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] map_reg
);

    rob_pkg::rob_tag_t     tail;      // next line to allocate
    logic [`ROB_WIDTH-1:0] accepted;  // leading run of valid lanes

    // a gap stops acceptance of every higher lane
    always_comb begin
        accepted[0] = dp_valid[0];
        for (int i = 1; i < `ROB_WIDTH; i++) begin
            accepted[i] = accepted[i-1] & dp_valid[i];
        end
    end

    // run length, counting the set bits of a leading run
    always_comb begin
        alloc.alloc_num = '0;
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            if (accepted[i]) begin
                alloc.alloc_num = rob_pkg::lane_cnt_t'(i + 1);
            end
        end
    end

    assign alloc.tail      = tail;
    assign alloc.alloc_mem = dp_mem;

    // rename info, same cycle as the request
    always_comb begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            dp_tag[i]           = tail + rob_pkg::rob_tag_t'(i);
            map_valid[i]        = accepted[i] & dp_dest_valid[i];
            map_reg[i]          = dp_dest_valid[i] ? dp_dest[i] : '0; // r0 = none
            alloc.alloc_dest[i] = map_reg[i];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (squash) begin
            tail <= '0;
        end else begin
            tail <= tail + rob_pkg::rob_tag_t'(alloc.alloc_num); // wraps mod depth
        end
    end

endmodule

//--- rtl/rob_retire.sv
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_retire (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 squash,
    input  rob_pkg::rob_entry_t [`ROB_WIDTH-1:0] head_entries,
    output rob_pkg::rob_tag_t                    head,
    output rob_pkg::lane_cnt_t                   retire_num,
    output logic                [`ROB_WIDTH-1:0] rt_valid,
    output rob_pkg::rob_tag_t   [`ROB_WIDTH-1:0] rt_tag,
    output rob_pkg::arch_reg_t  [`ROB_WIDTH-1:0] rt_dest,
    output rob_pkg::data_t      [`ROB_WIDTH-1:0] rt_value,
    output logic                [`ROB_WIDTH-1:0] rt_take_branch
);

    logic [`ROB_WIDTH-1:0] done;  // per lane result present
    logic [`ROB_WIDTH-1:0] mem;   // per lane memory op
    logic [`ROB_WIDTH-1:0] ret;   // lane retires this cycle

    always_comb begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            done[i] = head_entries[i].done;
            mem[i]  = head_entries[i].mem_op;
        end
    end

    // in order, and one memory op per group at most
    assign ret[0] = done[0];
    assign ret[1] = ret[0] & done[1] & ~(mem[0] & mem[1]);
    assign ret[2] = ret[1] & done[2] & ~((mem[0] | mem[1]) & mem[2]); // pair 0/1 already ruled out

    // ret is a leading run, so its length is the count
    always_comb begin
        retire_num = '0;
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            if (ret[i]) begin
                retire_num = rob_pkg::lane_cnt_t'(i + 1);
            end
        end
    end

    // idle lanes read all zero
    always_comb begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            rt_valid[i]       = ret[i];
            rt_tag[i]         = ret[i] ? head + rob_pkg::rob_tag_t'(i) : '0;
            rt_dest[i]        = ret[i] ? head_entries[i].dest : '0;
            rt_value[i]       = ret[i] ? head_entries[i].value : '0;
            rt_take_branch[i] = ret[i] & head_entries[i].take_branch;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else if (squash) begin
            head <= '0;  // buffer empties, back to line 0
        end else begin
            head <= head + rob_pkg::rob_tag_t'(retire_num);
        end
    end

endmodule

//--- rtl/rob_top.sv
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_top (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                squash,
    input  logic               [`ROB_WIDTH-1:0] dp_valid,
    input  logic               [`ROB_WIDTH-1:0] dp_dest_valid,
    input  rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] dp_dest,
    input  logic               [`ROB_WIDTH-1:0] dp_mem,
    input  logic               [`ROB_WIDTH-1:0] cdb_valid,
    input  rob_pkg::rob_tag_t  [`ROB_WIDTH-1:0] cdb_tag,
    input  rob_pkg::data_t     [`ROB_WIDTH-1:0] cdb_value,
    input  logic               [`ROB_WIDTH-1:0] cdb_take_branch,
    output rob_pkg::lane_cnt_t                  free_slots,
    output rob_pkg::rob_tag_t  [`ROB_WIDTH-1:0] dp_tag,
    output logic               [`ROB_WIDTH-1:0] map_valid,
    output rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] map_reg,
    output logic               [`ROB_WIDTH-1:0] rt_valid,
    output rob_pkg::rob_tag_t  [`ROB_WIDTH-1:0] rt_tag,
    output rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] rt_dest,
    output rob_pkg::data_t     [`ROB_WIDTH-1:0] rt_value,
    output logic               [`ROB_WIDTH-1:0] rt_take_branch
);

    rob_pkg::rob_tag_t                    head;
    rob_pkg::lane_cnt_t                   retire_num;
    rob_pkg::rob_entry_t [`ROB_WIDTH-1:0] head_entries;  // table -> retire

    rob_alloc_if alloc_bus ();  // dispatch -> table

    rob_dispatch u_dispatch (
        .clock         (clock),
        .rst_n         (rst_n),
        .squash        (squash),
        .dp_valid      (dp_valid),
        .dp_dest_valid (dp_dest_valid),
        .dp_dest       (dp_dest),
        .dp_mem        (dp_mem),
        .alloc         (alloc_bus.dispatch),
        .dp_tag        (dp_tag),
        .map_valid     (map_valid),
        .map_reg       (map_reg)
    );

    rob_entry_table u_table (
        .clock           (clock),
        .rst_n           (rst_n),
        .squash          (squash),
        .alloc           (alloc_bus.tbl),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_take_branch (cdb_take_branch),
        .head            (head),
        .retire_num      (retire_num),
        .head_entries    (head_entries),
        .free_slots      (free_slots)
    );

    rob_retire u_retire (
        .clock          (clock),
        .rst_n          (rst_n),
        .squash         (squash),
        .head_entries   (head_entries),
        .head           (head),
        .retire_num     (retire_num),
        .rt_valid       (rt_valid),
        .rt_tag         (rt_tag),
        .rt_dest        (rt_dest),
        .rt_value       (rt_value),
        .rt_take_branch (rt_take_branch)
    );

endmodule

//--- verification/rob_tb.sv
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_tb;

    localparam int CYCLE_LIMIT = 2000;  // five phases of at most 400 cycles

    // one in-flight instruction as the model sees it
    typedef struct packed {
        rob_pkg::rob_tag_t  tag;
        rob_pkg::arch_reg_t dest;   // already 0 when there is none
        logic               mem;
        logic               done;
        rob_pkg::data_t     value;
        logic               branch;
    } model_entry_t;

    logic                                clock;
    logic                                rst_n;
    logic                                squash;
    logic               [`ROB_WIDTH-1:0] dp_valid;
    logic               [`ROB_WIDTH-1:0] dp_dest_valid;
    rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] dp_dest;
    logic               [`ROB_WIDTH-1:0] dp_mem;
    logic               [`ROB_WIDTH-1:0] cdb_valid;
    rob_pkg::rob_tag_t  [`ROB_WIDTH-1:0] cdb_tag;
    rob_pkg::data_t     [`ROB_WIDTH-1:0] cdb_value;
    logic               [`ROB_WIDTH-1:0] cdb_take_branch;
    rob_pkg::lane_cnt_t                  free_slots;
    rob_pkg::rob_tag_t  [`ROB_WIDTH-1:0] dp_tag;
    logic               [`ROB_WIDTH-1:0] map_valid;
    rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] map_reg;
    logic               [`ROB_WIDTH-1:0] rt_valid;
    rob_pkg::rob_tag_t  [`ROB_WIDTH-1:0] rt_tag;
    rob_pkg::arch_reg_t [`ROB_WIDTH-1:0] rt_dest;
    rob_pkg::data_t     [`ROB_WIDTH-1:0] rt_value;
    logic               [`ROB_WIDTH-1:0] rt_take_branch;

    model_entry_t      model_q[$];   // oldest first
    rob_pkg::rob_tag_t next_tag;     // wraps mod 8 by width
    integer            seed;
    string             test_name;
    int                cycle_cnt = 0;

    rob_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic int pick_random(int n);
        int unsigned r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // expected free count, saturated at dispatch width
    function automatic rob_pkg::lane_cnt_t exp_free();
        int f;
        f = `ROB_DEPTH - model_q.size();
        if (f > `ROB_WIDTH) f = `ROB_WIDTH;
        return rob_pkg::lane_cnt_t'(f);
    endfunction

    // reference retire count: in order, done, one memory op per group
    function automatic int exp_retire_count();
        int n;
        int mems;
        n = 0;
        mems = 0;
        for (int i = 0; i < `ROB_WIDTH && i < model_q.size(); i++) begin
            if (!model_q[i].done || (model_q[i].mem && mems > 0)) break;
            mems += int'(model_q[i].mem);
            n++;
        end
        return n;
    endfunction

    task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
        $display("Mismatch %s %s expected %0h actual %0h", test_name, what, exp, act);
        $display("sim failed");
        $fatal(1, "first error reached");
    endtask

    task automatic check_tag(string what, rob_pkg::rob_tag_t exp, rob_pkg::rob_tag_t act);
        if (exp !== act) report_mismatch(what, 32'(exp), 32'(act));
    endtask

    task automatic check_reg(string what, rob_pkg::arch_reg_t exp, rob_pkg::arch_reg_t act);
        if (exp !== act) report_mismatch(what, 32'(exp), 32'(act));
    endtask

    task automatic check_word(string what, rob_pkg::data_t exp, rob_pkg::data_t act);
        if (exp !== act) report_mismatch(what, exp, act);
    endtask

    task automatic check_count(string what, rob_pkg::lane_cnt_t exp, rob_pkg::lane_cnt_t act);
        if (exp !== act) report_mismatch(what, 32'(exp), 32'(act));
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (exp !== act) report_mismatch(what, 32'(exp), 32'(act));
    endtask

    task automatic compare_outputs();
        int   n;
        logic acc;   // lane still inside the leading run
        n = exp_retire_count();
        acc = 1'b1;
        check_count("free_slots", exp_free(), free_slots);
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            acc = acc & dp_valid[i];
            check_tag($sformatf("dp_tag[%0d]", i), next_tag + rob_pkg::rob_tag_t'(i), dp_tag[i]);
            check_bit($sformatf("map_valid[%0d]", i), acc & dp_dest_valid[i], map_valid[i]);
            check_reg($sformatf("map_reg[%0d]", i), dp_dest_valid[i] ? dp_dest[i] : '0,
                      map_reg[i]);
            check_bit($sformatf("rt_valid[%0d]", i), i < n, rt_valid[i]);
            if (i < n) begin
                check_tag($sformatf("rt_tag[%0d]", i), model_q[i].tag, rt_tag[i]);
                check_reg($sformatf("rt_dest[%0d]", i), model_q[i].dest, rt_dest[i]);
                check_word($sformatf("rt_value[%0d]", i), model_q[i].value, rt_value[i]);
                check_bit($sformatf("rt_branch[%0d]", i), model_q[i].branch, rt_take_branch[i]);
            end else begin
                check_tag($sformatf("rt_tag[%0d]", i), '0, rt_tag[i]);  // idle lane reads zero
                check_reg($sformatf("rt_dest[%0d]", i), '0, rt_dest[i]);
                check_word($sformatf("rt_value[%0d]", i), '0, rt_value[i]);
                check_bit($sformatf("rt_branch[%0d]", i), 1'b0, rt_take_branch[i]);
            end
        end
    endtask

    // advance model to the state after the coming edge
    task automatic update_model();
        int           r;
        int           k;
        model_entry_t e;
        if (squash) begin
            model_q.delete();
            next_tag = '0;
        end else begin
            r = exp_retire_count();
            repeat (r) model_q.delete(0);
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                if (cdb_valid[i]) begin
                    k = -1;
                    for (int j = 0; j < model_q.size(); j++) begin
                        if (model_q[j].tag == cdb_tag[i]) k = j;
                    end
                    if (k < 0) begin
                        $display("completion for tag %0d that is not in flight", cdb_tag[i]);
                        $display("sim failed");
                        $fatal(1, "bad completion");
                    end
                    model_q[k].done   = 1'b1;
                    model_q[k].value  = cdb_value[i];
                    model_q[k].branch = cdb_take_branch[i];
                end
            end
            for (int i = 0; i < `ROB_WIDTH && dp_valid[i]; i++) begin
                e.tag    = next_tag;
                e.dest   = dp_dest_valid[i] ? dp_dest[i] : '0;
                e.mem    = dp_mem[i];
                e.done   = 1'b0;
                e.value  = '0;
                e.branch = 1'b0;
                model_q.push_back(e);
                next_tag = next_tag + 1'b1;
            end
        end
    endtask

    // sample before the rising edge, when inputs and outputs are settled
    always @(negedge clock) begin
        if (rst_n) begin
            compare_outputs();
            update_model();
        end
    end

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout: tests did not finish");
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic idle_inputs();
        squash          <= 1'b0;
        dp_valid        <= '0;
        dp_dest_valid   <= '0;
        dp_dest         <= '0;
        dp_mem          <= '0;
        cdb_valid       <= '0;
        cdb_tag         <= '0;
        cdb_value       <= '0;
        cdb_take_branch <= '0;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        idle_inputs();
    endtask

    // random lanes with gaps, leading run trimmed to the free count
    task automatic drive_dispatch();
        logic [`ROB_WIDTH-1:0] v;
        int                    lead;
        int                    room;
        v = 3'(pick_random(8));
        room = int'(exp_free());
        lead = 0;
        while (lead < `ROB_WIDTH && v[lead]) lead++;
        if (lead > room) v[room] = 1'b0;
        dp_valid <= v;
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            dp_dest_valid[i] <= 1'(pick_random(2));
            dp_dest[i]       <= rob_pkg::arch_reg_t'(pick_random(`ARCH_REGS));
            dp_mem[i]        <= 1'(pick_random(2));
        end
    endtask

    // up to want results for not-yet-done entries, distinct tags
    task automatic drive_complete(int want, bit newest_first);
        int cand[$];
        int k;
        int used;
        for (int i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].done) cand.push_back(i);
        end
        used = 0;
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            if (used < want && cand.size() > 0 && (newest_first || pick_random(4) != 0)) begin
                k = newest_first ? cand.size() - 1 : pick_random(cand.size());
                cdb_valid[i]       <= 1'b1;
                cdb_tag[i]         <= model_q[cand[k]].tag;
                cdb_value[i]       <= $random(seed);
                cdb_take_branch[i] <= 1'(pick_random(2));
                cand.delete(k);
                used++;
            end
        end
    endtask

    task automatic fill();
        while (model_q.size() < `ROB_DEPTH) begin
            next_cycle();
            drive_dispatch();
        end
    endtask

    task automatic drain(bit newest_first);
        while (model_q.size() > 0) begin
            next_cycle();
            drive_complete(newest_first ? `ROB_WIDTH : 1 + pick_random(3), newest_first);
        end
    endtask

    initial begin
        seed = 32'h85e5_cc46;
        next_tag = '0;
        test_name = "reset";
        rst_n = 1'b0;
        idle_inputs();
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;
        repeat (3) next_cycle();

        test_name = "rename";
        fill();
        repeat (2) next_cycle();  // full buffer reports 0

        test_name = "ooo_complete";
        drain(1'b0);

        test_name = "mem_rule";
        repeat (6) begin
            fill();
            drain(1'b1);  // youngest first, head finishes last
        end

        test_name = "squash";
        repeat (3) begin
            next_cycle();
            drive_dispatch();
        end
        next_cycle();
        drive_dispatch();
        drive_complete(2, 1'b0);
        squash <= 1'b1;
        repeat (3) next_cycle();
        next_cycle();
        dp_valid <= 3'b001;  // first tag after squash
        repeat (2) next_cycle();
        drain(1'b0);

        test_name = "random_mix";
        repeat (400) begin
            next_cycle();
            drive_dispatch();
            drive_complete(pick_random(4), 1'b0);
        end
        drain(1'b0);
        repeat (2) next_cycle();

        $display("sim passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_alloc_if.sv
rtl/rob_entry_table.sv
rtl/rob_dispatch.sv
rtl/rob_retire.sv
rtl/rob_top.sv
verification/rob_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the reorder buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module rob_tb -o rob_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/rob_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
